// ==== src/e100_pkg.sv ====
/* address map, port numbers and widths for the E100 memory-mapped I/O block,
   plus the word address union, word request and display structs */
package e100_pkg;

    localparam int data_width     = 32;
    localparam int ram_addr_width = 14;
    localparam int ram_words      = 1 << ram_addr_width;   // 16K words
    localparam int port_sel_width = 8;

    localparam logic [port_sel_width-1:0] port_switch    = 8'h00;
    localparam logic [port_sel_width-1:0] port_led_red   = 8'h01;
    localparam logic [port_sel_width-1:0] port_led_green = 8'h02;
    localparam logic [port_sel_width-1:0] port_hex_lo    = 8'h03;   // hex3..hex0
    localparam logic [port_sel_width-1:0] port_hex_hi    = 8'h04;   // hex7..hex4
    localparam logic [port_sel_width-1:0] port_timer     = 8'h05;

    localparam int switch_width    = 18;
    localparam int led_red_width   = 18;
    localparam int led_green_width = 8;
    localparam int hex_width       = 16;
    localparam int seg_width       = 7;

    localparam int timer_tick_cycles = 64;
    localparam int tick_cnt_width    = $clog2(timer_tick_cycles);

    // one word address, seen either as a RAM index or as a port number
    typedef union packed {
        struct packed {
            logic                                   is_io;
            logic [data_width-ram_addr_width-2:0]   unused;
            logic [ram_addr_width-1:0]              index;
        } ram;
        struct packed {
            logic                                   is_io;
            logic [data_width-port_sel_width-2:0]   unused;
            logic [port_sel_width-1:0]              port;
        } io;
    } word_addr_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        word_addr_t             addr;
        logic [data_width-1:0]  wdata;
    } word_req_t;

    // active low, bit 0 is segment a
    typedef struct packed {
        logic [seg_width-1:0] hex7;
        logic [seg_width-1:0] hex6;
        logic [seg_width-1:0] hex5;
        logic [seg_width-1:0] hex4;
        logic [seg_width-1:0] hex3;
        logic [seg_width-1:0] hex2;
        logic [seg_width-1:0] hex1;
        logic [seg_width-1:0] hex0;
    } seg_displays_t;

endpackage

// ==== src/host_bridge.sv ====
/* AXI4-Lite slave that turns one transaction at a time into a word request
   for the RAM or the I/O ports and returns the read word */
module host_bridge (
    input  logic                            clock,
    input  logic                            rst_n,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [e100_pkg::data_width-1:0] wdata,
    input  logic [3:0]                      wstrb,      // full-word writes only
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [31:0]                     araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [e100_pkg::data_width-1:0] rdata,
    output logic [1:0]                      rresp,

    output e100_pkg::word_req_t             ram_req,
    output e100_pkg::word_req_t             io_req,
    input  logic [e100_pkg::data_width-1:0] ram_rdata,
    input  logic [e100_pkg::data_width-1:0] io_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_wr_issue,
        st_wr_resp,
        st_rd_issue,
        st_rd_wait,
        st_rd_resp
    } state_t;

    state_t              state;
    e100_pkg::word_req_t req_q;     // addr stays put after issue, marks read target

    // byte address to word address, AXI bit 31 becomes the io flag
    function automatic e100_pkg::word_addr_t to_word_addr(input logic [31:0] byte_addr);
        return {byte_addr[31], 1'b0, byte_addr[31:2]};
    endfunction

    // write pair wins over a waiting read
    assign awready = (state == st_idle) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == st_idle) && arvalid && !(awvalid && wvalid);

    assign bresp = 2'b00;   // always OKAY
    assign rresp = 2'b00;

    // steer by the io flag, only the addressed side sees valid
    always_comb begin
        ram_req       = req_q;
        io_req        = req_q;
        ram_req.valid = req_q.valid && !req_q.addr.ram.is_io;
        io_req.valid  = req_q.valid && req_q.addr.io.is_io;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= st_idle;
            req_q.valid <= 1'b0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (awready) begin
                        req_q.valid <= 1'b1;
                        req_q.write <= 1'b1;
                        req_q.addr  <= to_word_addr(awaddr);
                        req_q.wdata <= wdata;
                        state       <= st_wr_issue;
                    end else if (arready) begin
                        req_q.valid <= 1'b1;
                        req_q.write <= 1'b0;
                        req_q.addr  <= to_word_addr(araddr);
                        state       <= st_rd_issue;
                    end
                end
                st_wr_issue: begin      // target writes on this edge
                    req_q.valid <= 1'b0;
                    bvalid      <= 1'b1;
                    state       <= st_wr_resp;
                end
                st_wr_resp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                st_rd_issue: begin
                    req_q.valid <= 1'b0;
                    state       <= st_rd_wait;
                end
                st_rd_wait: begin
                    rdata  <= req_q.addr.io.is_io ? io_rdata : ram_rdata;
                    rvalid <= 1'b1;
                    state  <= st_rd_resp;
                end
                st_rd_resp: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // responses are held until the host takes them
    bvalid_held: assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);
    rvalid_held: assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // each request reaches its target for one cycle only
    one_target: assert property (@(posedge clock) disable iff (!rst_n)
        ram_req.valid || io_req.valid |=> !ram_req.valid && !io_req.valid);

endmodule

// ==== src/word_ram.sv ====
/* 16K-word synchronous RAM, written and read by word requests,
   registered read data */
module word_ram (
    input  logic                            clock,
    input  e100_pkg::word_req_t             req,
    output logic [e100_pkg::data_width-1:0] rdata
);

    logic [e100_pkg::data_width-1:0] mem [e100_pkg::ram_words];

    logic [e100_pkg::ram_addr_width-1:0] index;

    assign index = req.addr.ram.index;     // io flag already checked upstream

    always_ff @(posedge clock) begin
        if (req.valid) begin
            if (req.write) begin
                mem[index] <= req.wdata;
            end else begin
                rdata <= mem[index];
            end
        end
    end

endmodule

// ==== src/io_ports.sv ====
/* I/O port registers, switch and timer inputs, seven-segment decode
   and the registered read mux */
module io_ports (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  e100_pkg::word_req_t                  req,
    input  logic [e100_pkg::switch_width-1:0]    sw,
    output logic [e100_pkg::data_width-1:0]      rdata,
    output logic [e100_pkg::led_red_width-1:0]   led_red,
    output logic [e100_pkg::led_green_width-1:0] led_green,
    output e100_pkg::seg_displays_t              displays
);

    logic [e100_pkg::hex_width-1:0]      hex_lo;
    logic [e100_pkg::hex_width-1:0]      hex_hi;
    logic [e100_pkg::data_width-1:0]     timer_q;
    logic [e100_pkg::tick_cnt_width-1:0] tick_cnt;
    logic [e100_pkg::data_width-1:0]     rd_word;
    logic [e100_pkg::port_sel_width-1:0] port;

    assign port = req.addr.io.port;

    // active low, {g,f,e,d,c,b,a}
    function automatic logic [e100_pkg::seg_width-1:0] seg_of(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;    // lower case b
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;    // lower case d
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // output ports, writes elsewhere are dropped
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            led_red   <= '0;
            led_green <= '0;
            hex_lo    <= '0;
            hex_hi    <= '0;
        end else if (req.valid && req.write) begin
            case (port)
                e100_pkg::port_led_red:   led_red   <= req.wdata[e100_pkg::led_red_width-1:0];
                e100_pkg::port_led_green: led_green <= req.wdata[e100_pkg::led_green_width-1:0];
                e100_pkg::port_hex_lo:    hex_lo    <= req.wdata[e100_pkg::hex_width-1:0];
                e100_pkg::port_hex_hi:    hex_hi    <= req.wdata[e100_pkg::hex_width-1:0];
                default: ;
            endcase
        end
    end

    // free-running timer, one step per tick period
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            timer_q  <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            if (int'(tick_cnt) == e100_pkg::timer_tick_cycles - 1) begin
                timer_q <= timer_q + 1'b1;
            end
        end
    end

    always_comb begin
        rd_word = '0;   // unmapped ports read zero
        case (port)
            e100_pkg::port_switch:    rd_word[e100_pkg::switch_width-1:0]    = sw;
            e100_pkg::port_led_red:   rd_word[e100_pkg::led_red_width-1:0]   = led_red;
            e100_pkg::port_led_green: rd_word[e100_pkg::led_green_width-1:0] = led_green;
            e100_pkg::port_hex_lo:    rd_word[e100_pkg::hex_width-1:0]       = hex_lo;
            e100_pkg::port_hex_hi:    rd_word[e100_pkg::hex_width-1:0]       = hex_hi;
            e100_pkg::port_timer:     rd_word                                = timer_q;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (req.valid && !req.write) begin
            rdata <= rd_word;
        end
    end

    always_comb begin
        displays.hex0 = seg_of(hex_lo[3:0]);
        displays.hex1 = seg_of(hex_lo[7:4]);
        displays.hex2 = seg_of(hex_lo[11:8]);
        displays.hex3 = seg_of(hex_lo[15:12]);
        displays.hex4 = seg_of(hex_hi[3:0]);
        displays.hex5 = seg_of(hex_hi[7:4]);
        displays.hex6 = seg_of(hex_hi[11:8]);
        displays.hex7 = seg_of(hex_hi[15:12]);
    end

    // timer only steps up by one, wrapping at the top
    timer_step: assert property (@(posedge clock) disable iff (!rst_n)
        timer_q != $past(timer_q) |-> timer_q == $past(timer_q) + 1'b1);

endmodule

// ==== src/e100_io_top.sv ====
/* E100 memory-mapped I/O top: AXI4-Lite bridge, word RAM and I/O ports */
module e100_io_top (
    input  logic                                 clock,
    input  logic                                 rst_n,

    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [31:0]                          awaddr,
    input  logic                                 wvalid,
    output logic                                 wready,
    input  logic [e100_pkg::data_width-1:0]      wdata,
    input  logic [3:0]                           wstrb,
    output logic                                 bvalid,
    input  logic                                 bready,
    output logic [1:0]                           bresp,

    input  logic                                 arvalid,
    output logic                                 arready,
    input  logic [31:0]                          araddr,
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic [e100_pkg::data_width-1:0]      rdata,
    output logic [1:0]                           rresp,

    input  logic [e100_pkg::switch_width-1:0]    sw,
    output logic [e100_pkg::led_red_width-1:0]   led_red,
    output logic [e100_pkg::led_green_width-1:0] led_green,
    output e100_pkg::seg_displays_t              displays
);

    e100_pkg::word_req_t             ram_req;
    e100_pkg::word_req_t             io_req;
    logic [e100_pkg::data_width-1:0] ram_rdata;
    logic [e100_pkg::data_width-1:0] io_rdata;

    host_bridge u_bridge (
        .clock     (clock),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .ram_req   (ram_req),
        .io_req    (io_req),
        .ram_rdata (ram_rdata),
        .io_rdata  (io_rdata)
    );

    word_ram u_ram (
        .clock (clock),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    io_ports u_ports (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (io_req),
        .sw        (sw),
        .rdata     (io_rdata),
        .led_red   (led_red),
        .led_green (led_green),
        .displays  (displays)
    );

endmodule

// ==== test/tb_e100_io.sv ====
/* testbench for the E100 I/O top: AXI4-Lite write and read tasks, LCG stimulus,
   reference model of RAM, ports and displays, and the final report */
module tb_e100_io;

    localparam int wait_limit = 200;    // cycles per handshake wait

    logic clock;
    logic rst_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic [e100_pkg::switch_width-1:0]    sw;
    logic [e100_pkg::led_red_width-1:0]   led_red;
    logic [e100_pkg::led_green_width-1:0] led_green;
    e100_pkg::seg_displays_t              displays;

    logic [31:0] lcg_state = 32'd87971;
    int unsigned cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;

    // reference model
    logic [31:0] ram_model [int];
    logic [31:0] led_red_model, led_green_model, hex_lo_model, hex_hi_model;

    logic [31:0] r, got, t1, t2;
    int unsigned idx, c1, c2;

    e100_io_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] rand_word();
        logic [31:0] upper;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        upper = lcg_state & 32'hffff_0000;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return upper | (lcg_state >> 16);   // high halves only
    endfunction

    function automatic logic [31:0] port_addr(input logic [7:0] port);
        return 32'h8000_0000 | (32'(port) << 2);
    endfunction

    // active-high gfedcba glyphs, inverted for the board's active-low segments
    function automatic logic [6:0] seg_glyph(input logic [3:0] nib);
        logic [6:0] lit [16];
        lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
        return ~lit[nib];
    endfunction

    function automatic logic [55:0] expected_displays();
        logic [55:0] d;
        for (int k = 0; k < 4; k++) begin
            d[7*k +: 7]      = seg_glyph(hex_lo_model[4*k +: 4]);
            d[7*(k+4) +: 7]  = seg_glyph(hex_hi_model[4*k +: 4]);
        end
        return d;
    endfunction

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: DUT never raised %s within %0d cycles", what, wait_limit);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        int n;
        int delay;
        @(posedge clock);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        n = 0;
        @(negedge clock);
        while (!awready && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!awready) report_timeout("awready");
        @(posedge clock);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge clock);
        while (!bvalid && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!bvalid) report_timeout("bvalid");
        delay = int'(rand_word() % 4);  // hold off bready
        repeat (delay) @(negedge clock);
        check("bresp", bresp, 2'b00);
        @(posedge clock);
        bready <= 1'b1;
        @(posedge clock);
        bready <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        int n;
        int delay;
        @(posedge clock);
        arvalid <= 1'b1;
        araddr  <= addr;
        n = 0;
        @(negedge clock);
        while (!arready && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!arready) report_timeout("arready");
        @(posedge clock);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clock);
        while (!rvalid && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!rvalid) report_timeout("rvalid");
        delay = int'(rand_word() % 4);
        repeat (delay) @(negedge clock);
        data = rdata;
        check("rresp", rresp, 2'b00);
        @(posedge clock);
        rready <= 1'b1;
        @(posedge clock);
        rready <= 1'b0;
    endtask

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;     // full words only
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        sw      = '0;
        led_red_model   = '0;
        led_green_model = '0;
        hex_lo_model    = '0;
        hex_hi_model    = '0;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;

        for (int i = 0; i < 60; i++) begin
            idx = rand_word() % 32;     // small range so reads hit written words
            r = rand_word();
            if (ram_model.exists(idx) && r[0]) begin
                read_word(idx << 2, got);
                check("ram readback", got, ram_model[idx]);
            end else begin
                ram_model[idx] = rand_word();
                write_word(idx << 2, ram_model[idx]);
            end
        end
        finish_test("ram random");

        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            led_red_model = r & 32'h3ffff;
            write_word(port_addr(e100_pkg::port_led_red), r);
            r = rand_word();
            led_green_model = r & 32'hff;
            write_word(port_addr(e100_pkg::port_led_green), r);
            @(negedge clock);
            check("led_red pins", led_red, led_red_model);
            check("led_green pins", led_green, led_green_model);
            read_word(port_addr(e100_pkg::port_led_red), got);
            check("led_red readback", got, led_red_model);
            read_word(port_addr(e100_pkg::port_led_green), got);
            check("led_green readback", got, led_green_model);
        end
        finish_test("leds");

        for (int i = 0; i < 6; i++) begin
            r = rand_word();
            hex_lo_model = r & 32'hffff;
            write_word(port_addr(e100_pkg::port_hex_lo), r);
            r = rand_word();
            hex_hi_model = r & 32'hffff;
            write_word(port_addr(e100_pkg::port_hex_hi), r);
            @(negedge clock);
            check("seven-segment displays", displays, expected_displays());
            read_word(port_addr(e100_pkg::port_hex_lo), got);
            check("hex_lo readback", got, hex_lo_model);
            read_word(port_addr(e100_pkg::port_hex_hi), got);
            check("hex_hi readback", got, hex_hi_model);
        end
        finish_test("hex displays");

        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            @(posedge clock);
            sw <= r[17:0];
            read_word(port_addr(e100_pkg::port_switch), got);
            check("switch readback", got, {14'b0, r[17:0]});
        end
        finish_test("switches");

        // both reads sample the timer at the same offset from their start
        c1 = cycle_count;
        read_word(port_addr(e100_pkg::port_timer), t1);
        repeat (100 + rand_word() % 300) @(posedge clock);
        c2 = cycle_count;
        read_word(port_addr(e100_pkg::port_timer), t2);
        check("timer not behind", t2 >= t1, 1'b1);
        check("timer step bound",
              (t2 - t1) <= (c2 - c1) / e100_pkg::timer_tick_cycles + 1, 1'b1);
        check("timer advanced",
              (t2 - t1) >= (c2 - c1) / e100_pkg::timer_tick_cycles, 1'b1);
        finish_test("timer");

        ram_model[1] = rand_word();
        write_word(32'h4, ram_model[1]);
        r = rand_word();
        led_red_model = r & 32'h3ffff;
        write_word(port_addr(e100_pkg::port_led_red), r);
        read_word(32'h4, got);
        check("ram index 1 after port write", got, ram_model[1]);
        read_word(port_addr(e100_pkg::port_led_red), got);
        check("led_red readback", got, led_red_model);
        write_word(port_addr(e100_pkg::port_switch), rand_word());
        write_word(port_addr(8'h77), rand_word());   // unmapped
        @(negedge clock);
        check("led_red unchanged", led_red, led_red_model);
        check("led_green unchanged", led_green, led_green_model);
        check("displays unchanged", displays, expected_displays());
        read_word(port_addr(8'h77), got);
        check("unmapped port reads zero", got, 32'h0);
        read_word(port_addr(e100_pkg::port_switch), got);
        check("switch port ignores writes", got, {14'b0, sw});
        finish_test("isolation");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
src/e100_pkg.sv
src/host_bridge.sv
src/word_ram.sv
src/io_ports.sv
src/e100_io_top.sv
test/tb_e100_io.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_e100_io \
    -o tb_e100_io > build.log 2>&1 &&
    ./obj_dir/tb_e100_io > sim.log 2>&1
grep -q "^TESTBENCH PASSED$" sim.log && echo "run.sh: simulation passed" && exit 0 ||
    { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; }
